// File: list.f
rtl/cpuPkg.sv
rtl/ctrlBus.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/instrMemory.sv
rtl/dataMemory.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/cpuTop.sv
bench/clockGen.sv
bench/cpuTb.sv

// File: Bender.yml
package:
  name: rv64_multicycle

sources:
  - rtl/cpuPkg.sv
  - rtl/ctrlBus.sv
  - rtl/alu.sv
  - rtl/registerFile.sv
  - rtl/instrMemory.sv
  - rtl/dataMemory.sv
  - rtl/controlUnit.sv
  - rtl/datapath.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/cpuTb.sv

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	logic clock;
	logic reset;
	logic progWrite;
	logic [memAddrWidth-1:0] progAddress;
	logic [instrWidth-1:0] progData;
	logic commitValid;
	logic commitWrite;
	logic [xlen-1:0] commitPc;
	logic [regAddrWidth-1:0] commitReg;
	logic [xlen-1:0] commitData;

	// stimulus table, one entry per program word
	logic [instrWidth-1:0] codeTable[$];
	logic [xlen-1:0] pcTable[$];
	logic writeTable[$];
	logic [regAddrWidth-1:0] regTable[$];
	logic [xlen-1:0] dataTable[$];
	logic skipTable[$];

	int valueErrors;
	int timeoutErrors;
	logic seen;

	clockGen u_clockGen
	(
		.clock(clock),
		.reset(reset)
	);

	cpuTop u_cpuTop
	(
		.clock(clock),
		.reset(reset),
		.progWrite(progWrite),
		.progAddress(progAddress),
		.progData(progData),
		.commitValid(commitValid),
		.commitWrite(commitWrite),
		.commitPc(commitPc),
		.commitReg(commitReg),
		.commitData(commitData)
	);

	// instruction encoders, field order as in the base isa
	function automatic logic [instrWidth-1:0] encodeR(input logic [6:0] funct7,
		input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] funct3,
		input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, opR};
	endfunction

	function automatic logic [instrWidth-1:0] encodeI(input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd,
		input logic [6:0] opcode);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic logic [instrWidth-1:0] encodeS(input logic [11:0] imm,
		input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] funct3);
		return {imm[11:5], rs2, rs1, funct3, imm[4:0], opStore};
	endfunction

	// byte offset, bit 0 is dropped by the format
	function automatic logic [instrWidth-1:0] encodeB(input logic [12:0] imm,
		input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] funct3);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [instrWidth-1:0] encodeU(input logic [19:0] imm,
		input logic [4:0] rd);
		return {imm, rd, opLui};
	endfunction

	// word i sits at byte address 4*i
	task automatic addEntry(input logic [instrWidth-1:0] code, input logic write,
		input logic [regAddrWidth-1:0] rd, input logic [xlen-1:0] data,
		input logic skip);
		pcTable.push_back(xlen'(4 * codeTable.size()));
		codeTable.push_back(code);
		writeTable.push_back(write);
		regTable.push_back(rd);
		dataTable.push_back(data);
		skipTable.push_back(skip);
	endtask

	task automatic buildProgram();
		// addi x1, x0, -5 then lui x2, 0x12345
		addEntry(encodeI(12'hffb, 5'd0, 3'b000, 5'd1, opImm),
			1'b1, 5'd1, 64'hffff_ffff_ffff_fffb, 1'b0);
		addEntry(encodeU(20'h12345, 5'd2),
			1'b1, 5'd2, 64'h0000_0000_1234_5000, 1'b0);
		// register ops, the sub goes below zero
		addEntry(encodeR(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3),
			1'b1, 5'd3, 64'h0000_0000_1234_4ffb, 1'b0);
		addEntry(encodeR(7'b0100000, 5'd2, 5'd3, 3'b000, 5'd4),
			1'b1, 5'd4, 64'hffff_ffff_ffff_fffb, 1'b0);
		addEntry(encodeR(7'b0000000, 5'd2, 5'd3, 3'b111, 5'd5),
			1'b1, 5'd5, 64'h0000_0000_1234_4000, 1'b0);
		addEntry(encodeR(7'b0000000, 5'd2, 5'd3, 3'b110, 5'd6),
			1'b1, 5'd6, 64'h0000_0000_1234_5ffb, 1'b0);
		// slli by 63, srli by 63, srai by 60 fills with the sign
		addEntry(encodeI({6'b000000, 6'd63}, 5'd1, 3'b001, 5'd7, opImm),
			1'b1, 5'd7, 64'h8000_0000_0000_0000, 1'b0);
		addEntry(encodeI({6'b000000, 6'd63}, 5'd7, 3'b101, 5'd8, opImm),
			1'b1, 5'd8, 64'h0000_0000_0000_0001, 1'b0);
		addEntry(encodeI({6'b010000, 6'd60}, 5'd7, 3'b101, 5'd9, opImm),
			1'b1, 5'd9, 64'hffff_ffff_ffff_fff8, 1'b0);
		// sd x7 to byte 16 then ld it back into x10
		addEntry(encodeS(12'd16, 5'd7, 5'd0, 3'b011),
			1'b0, 5'd0, 64'h0, 1'b0);
		addEntry(encodeI(12'd16, 5'd0, 3'b011, 5'd10, opLoad),
			1'b1, 5'd10, 64'h8000_0000_0000_0000, 1'b0);
		// beq x8, x8 is taken over the next word
		addEntry(encodeB(13'd8, 5'd8, 5'd8, 3'b000),
			1'b0, 5'd0, 64'h0, 1'b0);
		addEntry(encodeI(12'd1, 5'd0, 3'b000, 5'd11, opImm),
			1'b0, 5'd0, 64'h0, 1'b1);
		// bne on equal operands falls through
		addEntry(encodeB(13'd8, 5'd8, 5'd8, 3'b001),
			1'b0, 5'd0, 64'h0, 1'b0);
		// write to x0 is hidden, then x0 read as a plain zero operand
		addEntry(encodeI(12'd7, 5'd0, 3'b000, 5'd0, opImm),
			1'b0, 5'd0, 64'h0, 1'b0);
		addEntry(encodeR(7'b0000000, 5'd6, 5'd0, 3'b000, 5'd11),
			1'b1, 5'd11, 64'h0000_0000_1234_5ffb, 1'b0);
	endtask

	task automatic checkWord(input string name, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkReg(input string name, input logic [regAddrWidth-1:0] expected,
		input logic [regAddrWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	// commit fields are combinational, so look at them on the falling edge
	task automatic waitCommit(output logic found);
		int cycles;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < 50)
		begin
			@(negedge clock);
			found = (commitValid === 1'b1);
			cycles++;
		end
	endtask

	initial
	begin
		progWrite = 1'b0;
		progAddress = '0;
		progData = '0;
		valueErrors = 0;
		timeoutErrors = 0;
		seen = 1'b0;
		buildProgram();

		// program load while the core sits in reset
		for (int i = 0; i < codeTable.size(); i++)
		begin
			@(posedge clock);
			progWrite <= 1'b1;
			progAddress <= memAddrWidth'(i);
			progData <= codeTable[i];
		end
		@(posedge clock);
		progWrite <= 1'b0;

		// retirements in program order, skipped words never commit
		for (int i = 0; i < codeTable.size() && timeoutErrors == 0; i++)
		begin
			if (!skipTable[i])
			begin
				waitCommit(seen);
				if (!seen)
				begin
					$display("timed out waiting for the instruction at pc %h to retire",
						pcTable[i]);
					timeoutErrors++;
				end
				else
				begin
					checkWord("commitPc", pcTable[i], commitPc);
					checkBit("commitWrite", writeTable[i], commitWrite);
					// destination fields only mean something on a write
					if (writeTable[i])
					begin
						checkReg("commitReg", regTable[i], commitReg);
						checkWord("commitData", dataTable[i], commitData);
					end
				end
			end
		end

		$display("errors %0d value, %0d timeout", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clock,
	output logic reset
);

	// 10 ns period
	initial
	begin
		clock = 1'b0;
		forever
			#5 clock = ~clock;
	end

	// reset held for the first 16 rising edges
	initial
	begin
		reset = 1'b1;
		repeat (16)
			@(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop
(
	input logic clock,
	input logic reset,
	input logic progWrite,
	input logic [cpuPkg::memAddrWidth-1:0] progAddress,
	input logic [cpuPkg::instrWidth-1:0] progData,
	output logic commitValid,
	output logic commitWrite,
	output logic [cpuPkg::xlen-1:0] commitPc,
	output logic [cpuPkg::regAddrWidth-1:0] commitReg,
	output logic [cpuPkg::xlen-1:0] commitData
);
	import cpuPkg::*;

	// fetch side
	logic [instrWidth-1:0] instr;
	logic [memAddrWidth-1:0] instrAddress;
	// register file side
	logic [regAddrWidth-1:0] readAddrA;
	logic [regAddrWidth-1:0] readAddrB;
	logic [regAddrWidth-1:0] writeAddr;
	logic [xlen-1:0] readDataA;
	logic [xlen-1:0] readDataB;
	logic regWriteEnable;
	logic [xlen-1:0] regWriteData;
	// data memory side
	logic [memAddrWidth-1:0] dataAddress;
	logic [xlen-1:0] storeData;
	logic [xlen-1:0] loadData;
	logic memWriteEnable;

	ctrlBus bus();

	controlUnit u_controlUnit
	(
		.clock(clock),
		.reset(reset),
		.bus(bus.control),
		.commitValid(commitValid)
	);

	datapath u_datapath
	(
		.clock(clock),
		.reset(reset),
		.bus(bus.path),
		.instr(instr),
		.instrAddress(instrAddress),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeAddr(writeAddr),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.regWriteEnable(regWriteEnable),
		.regWriteData(regWriteData),
		.dataAddress(dataAddress),
		.storeData(storeData),
		.loadData(loadData),
		.memWriteEnable(memWriteEnable),
		.commitWrite(commitWrite),
		.commitPc(commitPc),
		.commitReg(commitReg),
		.commitData(commitData)
	);

	registerFile u_registerFile
	(
		.clock(clock),
		.reset(reset),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeAddr(writeAddr),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEnable(regWriteEnable),
		.writeData(regWriteData)
	);

	instrMemory u_instrMemory
	(
		.clock(clock),
		.readAddress(instrAddress),
		.readData(instr),
		.progWrite(progWrite),
		.progAddress(progAddress),
		.progData(progData)
	);

	dataMemory u_dataMemory
	(
		.clock(clock),
		.address(dataAddress),
		.writeData(storeData),
		.writeEnable(memWriteEnable),
		.readData(loadData)
	);

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ps

module datapath
(
	input logic clock,
	input logic reset,
	ctrlBus.path bus,
	input logic [cpuPkg::instrWidth-1:0] instr,
	output logic [cpuPkg::memAddrWidth-1:0] instrAddress,
	output logic [cpuPkg::regAddrWidth-1:0] readAddrA,
	output logic [cpuPkg::regAddrWidth-1:0] readAddrB,
	output logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	input logic [cpuPkg::xlen-1:0] readDataA,
	input logic [cpuPkg::xlen-1:0] readDataB,
	output logic regWriteEnable,
	output logic [cpuPkg::xlen-1:0] regWriteData,
	output logic [cpuPkg::memAddrWidth-1:0] dataAddress,
	output logic [cpuPkg::xlen-1:0] storeData,
	input logic [cpuPkg::xlen-1:0] loadData,
	output logic memWriteEnable,
	output logic commitWrite,
	output logic [cpuPkg::xlen-1:0] commitPc,
	output logic [cpuPkg::regAddrWidth-1:0] commitReg,
	output logic [cpuPkg::xlen-1:0] commitData
);
	import cpuPkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] instrPc;
	instrWord ir;
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] result;
	logic [xlen-1:0] mdr;
	logic [xlen-1:0] immValue;
	logic [xlen-1:0] operandA;
	logic [xlen-1:0] operandB;
	logic [xlen-1:0] aluResult;
	logic aluZero;

	// pc and the address of the instruction in flight
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			pc <= '0;
			instrPc <= '0;
		end
		else
		begin
			if (bus.pcWrite)
				pc <= bus.pcFromResult ? result : aluResult;
			if (bus.irLoad)
				instrPc <= pc;
		end
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		if (bus.irLoad)
			ir.raw <= instr;
		if (bus.opLoad)
		begin
			a <= readDataA;
			b <= readDataB;
		end
		if (bus.resultLoad)
			result <= aluResult;
		if (bus.mdrLoad)
			mdr <= loadData;
	end

	// immediates, the b form is kept in halfwords and doubled at the mux
	always_comb
	begin
		case (bus.immKind)
			immS: immValue = {{(xlen-12){ir.sType.immHi[6]}}, ir.sType.immHi, ir.sType.immLo};
			immB: immValue = {{(xlen-12){ir.bType.immSign}}, ir.bType.immSign,
				ir.bType.immBit11, ir.bType.immHigh, ir.bType.immLow};
			immU: immValue = {{(xlen-32){ir.uType.imm[19]}}, ir.uType.imm, 12'b0};
			default: immValue = {{(xlen-12){ir.iType.imm[11]}}, ir.iType.imm};
		endcase
	end

	// during fetch the new address is still only in pc
	assign operandA = (bus.srcA == srcAReg) ? a : (bus.irLoad ? pc : instrPc);

	always_comb
	begin
		case (bus.srcB)
			srcBReg: operandB = b;
			srcBFour: operandB = xlen'(4);
			srcBImm: operandB = immValue;
			srcBBranch: operandB = immValue << 1;
		endcase
	end

	alu u_alu
	(
		.a(operandA),
		.b(operandB),
		.op(bus.aluOp),
		.shamt(ir.iType.imm[5:0]),
		.result(aluResult),
		.zero(aluZero)
	);

	assign bus.ir = ir;
	assign bus.zero = aluZero;

	// lui reads x0 so the alu sees 0 + imm
	assign readAddrA = (ir.uType.opcode == opLui) ? '0 : ir.rType.rs1;
	assign readAddrB = ir.rType.rs2;
	assign writeAddr = ir.rType.rd;

	// word indices, 4-byte instructions and 8-byte data
	assign instrAddress = pc[memAddrWidth+1:2];
	assign dataAddress = result[memAddrWidth+2:3];
	assign storeData = b;
	assign memWriteEnable = bus.memWrite;

	assign regWriteData = bus.wbFromMemory ? mdr : result;
	// x0 writes are dropped here and hidden from the commit record
	assign regWriteEnable = bus.regWrite && (writeAddr != '0);

	assign commitWrite = regWriteEnable;
	assign commitPc = instrPc;
	assign commitReg = writeAddr;
	assign commitData = regWriteData;

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
(
	input logic clock,
	input logic reset,
	ctrlBus.control bus,
	output logic commitValid
);
	import cpuPkg::*;

	logic [2:0] state;
	logic [2:0] nextState;
	instrWord ir;
	logic [2:0] regAluOp;
	logic [2:0] immAluOp;
	logic branchTaken;

	assign ir = bus.ir;

	// register-register ops, funct7 bit 5 picks sub
	always_comb
	begin
		case (ir.rType.funct3)
			3'b111: regAluOp = aluAnd;
			3'b110: regAluOp = aluOr;
			default: regAluOp = ir.rType.funct7[5] ? aluSub : aluAdd;
		endcase
	end

	// immediate ops, instruction bit 30 splits srai from srli
	always_comb
	begin
		case (ir.iType.funct3)
			3'b001: immAluOp = aluSll;
			3'b101: immAluOp = ir.iType.imm[10] ? aluSra : aluSrl;
			default: immAluOp = aluAdd;
		endcase
	end

	// beq on zero, bne on not zero
	assign branchTaken = ir.bType.funct3[0] ? !bus.zero : bus.zero;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= stFetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		// idle levels
		bus.pcWrite = 1'b0;
		bus.irLoad = 1'b0;
		bus.opLoad = 1'b0;
		bus.resultLoad = 1'b0;
		bus.mdrLoad = 1'b0;
		bus.regWrite = 1'b0;
		bus.memWrite = 1'b0;
		bus.aluOp = aluAdd;
		bus.srcA = srcAReg;
		bus.srcB = srcBReg;
		bus.immKind = immI;
		bus.wbFromMemory = 1'b0;
		bus.pcFromResult = 1'b0;
		commitValid = 1'b0;
		nextState = stFetch;
		case (state)
			stFetch:
			begin
				// ir takes mem[pc], pc steps by four
				bus.irLoad = 1'b1;
				bus.pcWrite = 1'b1;
				bus.srcA = srcAPc;
				bus.srcB = srcBFour;
				nextState = stDecode;
			end
			stDecode:
			begin
				// operands in, branch target computed ahead of time
				bus.opLoad = 1'b1;
				bus.resultLoad = 1'b1;
				bus.srcA = srcAPc;
				bus.srcB = srcBBranch;
				bus.immKind = immB;
				case (ir.rType.opcode)
					opR, opImm, opLui, opLoad, opStore, opBranch:
						nextState = stExecute;
					// unknown opcode retires here as a nop
					default:
						commitValid = 1'b1;
				endcase
			end
			stExecute:
			begin
				bus.resultLoad = 1'b1;
				nextState = stWriteback;
				case (ir.rType.opcode)
					opR:
						bus.aluOp = regAluOp;
					opImm:
					begin
						bus.srcB = srcBImm;
						bus.aluOp = immAluOp;
					end
					opLui:
					begin
						// rs1 is forced to x0, so this is 0 + imm
						bus.srcB = srcBImm;
						bus.immKind = immU;
					end
					opLoad:
					begin
						bus.srcB = srcBImm;
						nextState = stMemory;
					end
					opStore:
					begin
						bus.srcB = srcBImm;
						bus.immKind = immS;
						nextState = stMemory;
					end
					default:
					begin
						// branch compare, target stays in result
						bus.resultLoad = 1'b0;
						bus.aluOp = aluSub;
						bus.pcWrite = branchTaken;
						bus.pcFromResult = 1'b1;
						commitValid = 1'b1;
						nextState = stFetch;
					end
				endcase
			end
			stMemory:
			begin
				if (ir.rType.opcode == opLoad)
				begin
					bus.mdrLoad = 1'b1;
					nextState = stWriteback;
				end
				else
				begin
					bus.memWrite = 1'b1;
					commitValid = 1'b1;
				end
			end
			stWriteback:
			begin
				bus.regWrite = 1'b1;
				bus.wbFromMemory = (ir.rType.opcode == opLoad);
				commitValid = 1'b1;
			end
			default:
				nextState = stFetch;
		endcase
	end

endmodule

// File: rtl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
(
	input logic clock,
	input logic [cpuPkg::memAddrWidth-1:0] address,
	input logic [cpuPkg::xlen-1:0] writeData,
	input logic writeEnable,
	output logic [cpuPkg::xlen-1:0] readData
);
	import cpuPkg::*;

	logic [xlen-1:0] words [0:(1<<memAddrWidth)-1];

	// full doubleword stores only
	always_ff @(posedge clock)
	begin
		if (writeEnable)
			words[address] <= writeData;
	end

	// load data is ready in the same cycle
	assign readData = words[address];

endmodule

// File: rtl/instrMemory.sv
`timescale 1ns/1ps

module instrMemory
(
	input logic clock,
	input logic [cpuPkg::memAddrWidth-1:0] readAddress,
	output logic [cpuPkg::instrWidth-1:0] readData,
	input logic progWrite,
	input logic [cpuPkg::memAddrWidth-1:0] progAddress,
	input logic [cpuPkg::instrWidth-1:0] progData
);
	import cpuPkg::*;

	logic [instrWidth-1:0] words [0:(1<<memAddrWidth)-1];

	// program load port, independent of core reset
	always_ff @(posedge clock)
	begin
		if (progWrite)
			words[progAddress] <= progData;
	end

	// fetch reads without a clock
	assign readData = words[readAddress];

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile
(
	input logic clock,
	input logic reset,
	input logic [cpuPkg::regAddrWidth-1:0] readAddrA,
	input logic [cpuPkg::regAddrWidth-1:0] readAddrB,
	input logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	output logic [cpuPkg::xlen-1:0] readDataA,
	output logic [cpuPkg::xlen-1:0] readDataB,
	input logic writeEnable,
	input logic [cpuPkg::xlen-1:0] writeData
);
	import cpuPkg::*;

	logic [xlen-1:0] regs [0:(1<<regAddrWidth)-1];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < (1 << regAddrWidth); i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	// x0 hardwired
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu
(
	input logic [cpuPkg::xlen-1:0] a,
	input logic [cpuPkg::xlen-1:0] b,
	input logic [2:0] op,
	input logic [5:0] shamt,
	output logic [cpuPkg::xlen-1:0] result,
	output logic zero
);
	import cpuPkg::*;

	always_comb
	begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			// shifts take their amount from the instruction, not from b
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = $signed(a) >>> shamt;
			default: result = '0;
		endcase
	end

	// equality test for branches
	assign zero = (result == '0);

endmodule

// File: rtl/ctrlBus.sv
`timescale 1ns/1ps

interface ctrlBus;
	import cpuPkg::*;

	// register load strobes
	logic pcWrite;
	logic irLoad;
	logic opLoad;
	logic resultLoad;
	logic mdrLoad;
	// writes into storage
	logic regWrite;
	logic memWrite;
	// alu and operand selection
	logic [2:0] aluOp;
	logic srcA;
	logic [1:0] srcB;
	logic [1:0] immKind;
	logic wbFromMemory;
	logic pcFromResult;
	// status back from the datapath
	instrWord ir;
	logic zero;

	modport control
	(
		output pcWrite, irLoad, opLoad, resultLoad, mdrLoad,
		output regWrite, memWrite, aluOp, srcA, srcB, immKind,
		output wbFromMemory, pcFromResult,
		input ir, zero
	);

	modport path
	(
		input pcWrite, irLoad, opLoad, resultLoad, mdrLoad,
		input regWrite, memWrite, aluOp, srcA, srcB, immKind,
		input wbFromMemory, pcFromResult,
		output ir, zero
	);

endinterface

// File: rtl/cpuPkg.sv
package cpuPkg;

	// datapath and instruction widths
	localparam int xlen = 64;
	localparam int instrWidth = 32;
	localparam int regAddrWidth = 5;
	// word index into either memory
	localparam int memAddrWidth = 8;

	// major opcodes of the kept subset
	localparam logic [6:0] opR = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;

	// alu selector
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr = 3'd3;
	localparam logic [2:0] aluSll = 3'd4;
	localparam logic [2:0] aluSrl = 3'd5;
	localparam logic [2:0] aluSra = 3'd6;

	// operand a source
	localparam logic srcAPc = 1'b0;
	localparam logic srcAReg = 1'b1;

	// operand b source
	localparam logic [1:0] srcBReg = 2'd0;
	localparam logic [1:0] srcBFour = 2'd1;
	localparam logic [1:0] srcBImm = 2'd2;
	localparam logic [1:0] srcBBranch = 2'd3;

	// immediate format
	localparam logic [1:0] immI = 2'd0;
	localparam logic [1:0] immS = 2'd1;
	localparam logic [1:0] immB = 2'd2;
	localparam logic [1:0] immU = 2'd3;

	// control states
	localparam logic [2:0] stFetch = 3'd0;
	localparam logic [2:0] stDecode = 3'd1;
	localparam logic [2:0] stExecute = 3'd2;
	localparam logic [2:0] stMemory = 3'd3;
	localparam logic [2:0] stWriteback = 3'd4;

	// one instruction word seen through each encoding format
	typedef union packed
	{
		logic [instrWidth-1:0] raw;
		struct packed
		{
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rType;
		struct packed
		{
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} iType;
		struct packed
		{
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} sType;
		// offset bits 12, 10:5, 4:1 and 11 in encoding order
		struct packed
		{
			logic immSign;
			logic [5:0] immHigh;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] immLow;
			logic immBit11;
			logic [6:0] opcode;
		} bType;
		struct packed
		{
			logic [19:0] imm;
			logic [4:0] rd;
			logic [6:0] opcode;
		} uType;
	} instrWord;

endpackage
